// File: hdl/conv_store_pkg.sv
package conv_store_pkg;

  ////////////////////
  // widths

  // one sa row: 16 columns x 2 pixels x 8 bits
  parameter int word_w = 256;
  // one ddr beat holds up to two words
  parameter int beat_w = 512;
  parameter int adr_w = 32;
  parameter int len_w = 16;

  // features stored per fifo group
  parameter int group_features = 16;

  // defaults for the top level parameters
  parameter int default_num_groups = 4;
  parameter int default_fifo_depth = 16;

  ////////////////////
  // structs

  typedef struct packed {
    logic [adr_w-1:0] base_adr;
    logic             mode;
    logic [15:0]      ox_start;
    logic [15:0]      oy_start;
    logic [15:0]      of_start;
    logic [15:0]      pox;
    logic [15:0]      poy;
    logic [3:0]       of_in_2pow;
    logic [3:0]       ox_in_2pow;
  } tile_cfg_t;

  // adr in beat units, length in beats
  typedef struct packed {
    logic [adr_w-1:0] adr;
    logic [len_w-1:0] length;
  } ddr_cmd_t;

endpackage

// File: hdl/output_fifo_bank.sv
`timescale 1ns/10ps

module output_fifo_bank #(
  parameter int num_groups = 4,
  parameter int fifo_depth = 16
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                push,
  input  logic [$clog2(num_groups)-1:0]       push_group,
  input  logic [conv_store_pkg::word_w-1:0]   push_data,
  input  logic                                rd,
  input  logic [$clog2(num_groups)-1:0]       rd_group,
  output logic [conv_store_pkg::word_w-1:0]   rd_data,
  output logic [num_groups-1:0]               empty
);

  import conv_store_pkg::*;

  localparam int gw = $clog2(num_groups);
  localparam int aw = $clog2(fifo_depth);

  logic [word_w-1:0]     head [num_groups];
  logic [num_groups-1:0] full;

  for (genvar g = 0; g < num_groups; g++) begin : g_fifo
    logic [word_w-1:0] mem [fifo_depth];
    logic [aw-1:0]     wr_ptr;
    logic [aw-1:0]     rd_ptr;
    logic [aw:0]       count;
    logic              wr_en;
    logic              rd_en;

    assign wr_en = push && (push_group == gw'(g));
    assign rd_en = rd && (rd_group == gw'(g));

    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[wr_ptr] <= push_data;
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
          rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
        end
        // simultaneous push and pop leaves the count alone
        case ({wr_en, rd_en})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end

    assign head[g]  = mem[rd_ptr];
    assign empty[g] = (count == '0);
    assign full[g]  = (count == (aw + 1)'(fifo_depth));
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    if (rd) begin
      rd_data <= head[rd_group];
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) push |-> !full[push_group]
  );

  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset) rd |-> !empty[rd_group]
  );

endmodule

// File: hdl/store_addr_gen.sv
`timescale 1ns/10ps

module store_addr_gen #(
  parameter int num_groups = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  conv_store_pkg::tile_cfg_t     cfg,
  input  logic [15:0]                   row_idx,
  input  logic [$clog2(num_groups)-1:0] group_idx,
  input  logic                          calc,
  output conv_store_pkg::ddr_cmd_t      cmd
);

  import conv_store_pkg::*;

  logic [adr_w-1:0] row_y;
  logic [adr_w-1:0] pix_off;
  logic [adr_w-1:0] feat_off;
  logic [len_w-1:0] len_next;

  // output row inside the layer
  assign row_y = adr_w'(cfg.oy_start) + adr_w'(row_idx);

  // (y * width + x) * features, strides are powers of two
  assign pix_off = ((row_y << cfg.ox_in_2pow) + adr_w'(cfg.ox_start)) << cfg.of_in_2pow;

  // feature offset of this fifo group
  assign feat_off = adr_w'(cfg.of_start) + adr_w'(group_idx) * adr_w'(group_features);

  // mode 1 packs two words per beat
  assign len_next = cfg.mode ? (cfg.pox >> 1) : cfg.pox;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd <= '0;
    end else if (calc) begin
      cmd.adr    <= cfg.base_adr + pix_off + feat_off;
      cmd.length <= len_next;
    end
  end

  a_pair_even: assert property (
    @(posedge clk) disable iff (reset) (calc && cfg.mode) |-> !cfg.pox[0]
  );

endmodule

// File: hdl/beat_packer.sv
`timescale 1ns/10ps

module beat_packer (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              mode,
  input  logic [31:0]                       cmd_adr,
  input  logic                              rd_fire,
  input  logic                              first_word,
  input  logic [conv_store_pkg::word_w-1:0] rd_data,
  output logic [conv_store_pkg::beat_w-1:0] beat_data,
  output logic [31:0]                       beat_adr,
  output logic                              beat_valid,
  output logic                              last_beat_seen
);

  import conv_store_pkg::*;

  logic              fire_d;
  logic              first_d;
  logic              pair_half;
  logic              half_now;
  logic [word_w-1:0] lo_word;
  logic [31:0]       next_adr;

  // read strobes lined up with the fifo data
  always_ff @(posedge clk) begin
    if (reset) begin
      fire_d  <= 1'b0;
      first_d <= 1'b0;
    end else begin
      fire_d  <= rd_fire;
      first_d <= rd_fire && first_word;
    end
  end

  // first word of a command always opens a new pair
  assign half_now = first_d ? 1'b0 : pair_half;

  ////////////////////
  // packing

  assign beat_valid = fire_d && (!mode || half_now);
  assign beat_data  = mode ? {rd_data, lo_word} : {{(beat_w - word_w){1'b0}}, rd_data};

  always_ff @(posedge clk) begin
    if (reset) begin
      pair_half <= 1'b0;
    end else if (fire_d && mode) begin
      pair_half <= !half_now;
    end
  end

  // lower half waits here for its partner
  always_ff @(posedge clk) begin
    if (fire_d && !half_now) begin
      lo_word <= rd_data;
    end
  end

  ////////////////////
  // beat address

  assign beat_adr = first_d ? cmd_adr : next_adr;

  always_ff @(posedge clk) begin
    if (reset) begin
      next_adr <= '0;
    end else if (beat_valid) begin
      next_adr <= beat_adr + 32'd1;
    end else if (first_d) begin
      next_adr <= cmd_adr;
    end
  end

  // controller watches this for the closing beat of the tile
  assign last_beat_seen = beat_valid;

endmodule

// File: hdl/conv_store_ctrl.sv
`timescale 1ns/10ps

module conv_store_ctrl #(
  parameter int num_groups = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  conv_store_pkg::tile_cfg_t     cfg,
  input  logic [num_groups-1:0]         empty,
  input  logic                          ddr_cmd_ready,
  input  logic                          ddr_data_ready,
  output logic [15:0]                   row_idx,
  output logic [$clog2(num_groups)-1:0] group_idx,
  output logic                          calc,
  output logic                          cmd_valid,
  output logic                          rd,
  output logic [$clog2(num_groups)-1:0] rd_group,
  output logic                          first_word,
  input  logic                          last_beat_seen,
  output logic                          tile_done
);

  localparam int gw = $clog2(num_groups);

  typedef enum logic [2:0] {
    s_idle,
    s_calc,
    s_wait_cmd,
    s_drain,
    s_advance,
    s_flush
  } state_t;

  state_t      state;
  logic [15:0] word_cnt;
  logic        last_word;
  logic        last_group;
  logic        last_row;

  assign last_group = (group_idx == gw'(num_groups - 1));
  assign last_row   = (row_idx == cfg.poy - 16'd1);
  assign last_word  = (word_cnt == cfg.pox - 16'd1);

  ////////////////////
  // strobes

  // address gen samples row and group here
  assign calc = (state == s_calc);

  // command goes out as soon as ddr takes it
  assign cmd_valid = (state == s_wait_cmd) && ddr_cmd_ready;

  // read only with sink ready, data present and words left
  assign rd = (state == s_drain) && ddr_data_ready && !empty[group_idx]
              && (word_cnt != cfg.pox);

  assign rd_group   = group_idx;
  assign first_word = rd && (word_cnt == 16'd0);

  ////////////////////
  // walk fsm

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= s_idle;
      row_idx   <= '0;
      group_idx <= '0;
      word_cnt  <= '0;
      tile_done <= 1'b0;
    end else begin
      tile_done <= 1'b0;
      case (state)
        s_idle: begin
          if (start) begin
            row_idx   <= '0;
            group_idx <= '0;
            state     <= s_calc;
          end
        end
        s_calc: begin
          state <= s_wait_cmd;
        end
        s_wait_cmd: begin
          if (ddr_cmd_ready) begin
            word_cnt <= '0;
            state    <= s_drain;
          end
        end
        s_drain: begin
          if (rd) begin
            word_cnt <= word_cnt + 16'd1;
            if (last_word) begin
              state <= (last_row && last_group) ? s_flush : s_advance;
            end
          end
        end
        s_advance: begin
          // groups inner, rows outer
          if (last_group) begin
            group_idx <= '0;
            row_idx   <= row_idx + 16'd1;
          end else begin
            group_idx <= group_idx + 1'b1;
          end
          state <= s_calc;
        end
        s_flush: begin
          // closing beat leaves the packer one cycle after the final read
          if (last_beat_seen) begin
            tile_done <= 1'b1;
            state     <= s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  ////////////////////
  // checks

  // the read that ends the tile must produce a beat on the next cycle
  a_flush_beat: assert property (
    @(posedge clk) disable iff (reset) (state == s_flush) |-> last_beat_seen
  );

endmodule

// File: hdl/conv_store_top.sv
`timescale 1ns/10ps

module conv_store_top #(
  parameter int num_groups = conv_store_pkg::default_num_groups,
  parameter int fifo_depth = conv_store_pkg::default_fifo_depth
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  conv_store_pkg::tile_cfg_t         cfg,
  input  logic                              push,
  input  logic [$clog2(num_groups)-1:0]     push_group,
  input  logic [conv_store_pkg::word_w-1:0] push_data,
  input  logic                              ddr_cmd_ready,
  input  logic                              ddr_data_ready,
  output conv_store_pkg::ddr_cmd_t          cmd,
  output logic                              cmd_valid,
  output logic [conv_store_pkg::beat_w-1:0] beat_data,
  output logic [31:0]                       beat_adr,
  output logic                              beat_valid,
  output logic                              tile_done
);

  import conv_store_pkg::*;

  localparam int gw = $clog2(num_groups);

  tile_cfg_t         cfg_q;
  logic [num_groups-1:0] empty;
  logic [15:0]       row_idx;
  logic [gw-1:0]     group_idx;
  logic [gw-1:0]     rd_group;
  logic              calc;
  logic              rd;
  logic              first_word;
  logic [word_w-1:0] rd_data;
  logic              last_beat_seen;

  // tile configuration held for the whole walk
  always_ff @(posedge clk) begin
    if (start) begin
      cfg_q <= cfg;
    end
  end

  output_fifo_bank #(
    .num_groups (num_groups),
    .fifo_depth (fifo_depth)
  ) output_fifo_bank_inst (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_group (push_group),
    .push_data  (push_data),
    .rd         (rd),
    .rd_group   (rd_group),
    .rd_data    (rd_data),
    .empty      (empty)
  );

  conv_store_ctrl #(
    .num_groups (num_groups)
  ) conv_store_ctrl_inst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .cfg            (cfg_q),
    .empty          (empty),
    .ddr_cmd_ready  (ddr_cmd_ready),
    .ddr_data_ready (ddr_data_ready),
    .row_idx        (row_idx),
    .group_idx      (group_idx),
    .calc           (calc),
    .cmd_valid      (cmd_valid),
    .rd             (rd),
    .rd_group       (rd_group),
    .first_word     (first_word),
    .last_beat_seen (last_beat_seen),
    .tile_done      (tile_done)
  );

  store_addr_gen #(
    .num_groups (num_groups)
  ) store_addr_gen_inst (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg_q),
    .row_idx   (row_idx),
    .group_idx (group_idx),
    .calc      (calc),
    .cmd       (cmd)
  );

  beat_packer beat_packer_inst (
    .clk            (clk),
    .reset          (reset),
    .mode           (cfg_q.mode),
    .cmd_adr        (cmd.adr),
    .rd_fire        (rd),
    .first_word     (first_word),
    .rd_data        (rd_data),
    .beat_data      (beat_data),
    .beat_adr       (beat_adr),
    .beat_valid     (beat_valid),
    .last_beat_seen (last_beat_seen)
  );

endmodule

// File: verification/store_checker.sv
`timescale 1ns/10ps

module store_checker (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  conv_store_pkg::tile_cfg_t         cfg,
  input  logic                              push,
  input  logic [1:0]                        push_group,
  input  logic [conv_store_pkg::word_w-1:0] push_data,
  input  conv_store_pkg::ddr_cmd_t          cmd,
  input  logic                              cmd_valid,
  input  logic [conv_store_pkg::beat_w-1:0] beat_data,
  input  logic [31:0]                       beat_adr,
  input  logic                              beat_valid,
  input  logic                              tile_done,
  output int                                errors,
  output int                                cmd_count,
  output int                                beat_count,
  output int                                done_count
);

  import conv_store_pkg::*;

  // copy of every pushed word, 64 slots per group
  logic [word_w-1:0] q_mem [0:255];
  int                q_wr [4];
  int                q_rd [4];

  tile_cfg_t   cur_cfg;
  int          row;
  int          grp;
  int          words_left;
  int          beat_idx;
  logic [31:0] cur_adr;
  logic        in_cmd;
  logic        final_prev;

  function automatic logic [31:0] walk_adr(tile_cfg_t c, int r, int g);
    logic [31:0] y;
    logic [31:0] pix;
    y   = 32'(c.oy_start) + 32'(r);
    pix = ((y << c.ox_in_2pow) + 32'(c.ox_start)) << c.of_in_2pow;
    return c.base_adr + pix + 32'(c.of_start) + 32'(g * group_features);
  endfunction

  task automatic report_mismatch(string name, logic [511:0] exp, logic [511:0] act);
    $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic pop_word(output logic [word_w-1:0] w);
    if (q_rd[grp] >= q_wr[grp]) begin
      $display("ERROR t=%0t beat needs a word that was never pushed to group %0d",
               $time, grp);
      errors++;
      w = '0;
    end else begin
      w = q_mem[grp * 64 + q_rd[grp]];
      q_rd[grp]++;
    end
  endtask

  initial begin
    errors = 0;
  end

  always @(posedge clk) begin
    logic [word_w-1:0] w0;
    logic [word_w-1:0] w1;
    logic [beat_w-1:0] exp_beat;
    logic              final_now;
    final_now = 1'b0;
    if (reset || start) begin
      // a fresh tile or a reset starts with empty fifos
      for (int g = 0; g < 4; g++) begin
        q_wr[g] = 0;
        q_rd[g] = 0;
      end
      row        = 0;
      grp        = 0;
      in_cmd     = 1'b0;
      cmd_count  = 0;
      beat_count = 0;
      done_count = 0;
      cur_cfg    = cfg;
    end else begin
      ////////////////////
      // beats
      if (beat_valid) begin
        beat_count++;
        if (!in_cmd) begin
          $display("ERROR t=%0t beat arrived outside a command", $time);
          errors++;
        end else begin
          pop_word(w0);
          if (cur_cfg.mode) begin
            pop_word(w1);
            exp_beat = {w1, w0};
            words_left -= 2;
          end else begin
            exp_beat = {{(beat_w - word_w){1'b0}}, w0};
            words_left -= 1;
          end
          if (beat_data !== exp_beat) report_mismatch("beat_data", exp_beat, beat_data);
          if (beat_adr !== cur_adr + 32'(beat_idx)) begin
            report_mismatch("beat_adr", cur_adr + 32'(beat_idx), beat_adr);
          end
          beat_idx++;
          if (words_left <= 0) begin
            in_cmd = 1'b0;
            grp++;
            if (grp == 4) begin
              grp = 0;
              row++;
            end
            final_now = (row == int'(cur_cfg.poy));
          end
        end
      end
      ////////////////////
      // commands
      if (cmd_valid) begin
        cmd_count++;
        if (in_cmd || row >= int'(cur_cfg.poy)) begin
          $display("ERROR t=%0t command issued out of walk order", $time);
          errors++;
        end
        cur_adr = walk_adr(cur_cfg, row, grp);
        if (cmd.adr !== cur_adr) report_mismatch("cmd.adr", cur_adr, cmd.adr);
        if (cmd.length !== (cur_cfg.mode ? cur_cfg.pox >> 1 : cur_cfg.pox)) begin
          report_mismatch("cmd.length", cur_cfg.mode ? cur_cfg.pox >> 1 : cur_cfg.pox,
                          cmd.length);
        end
        words_left = int'(cur_cfg.pox);
        beat_idx   = 0;
        in_cmd     = 1'b1;
      end
      if (tile_done) begin
        done_count++;
        if (!final_prev) begin
          $display("ERROR t=%0t tile_done not one cycle after the last beat", $time);
          errors++;
        end
      end
    end
    // the fifos take a word in the start cycle too, but not under reset
    if (push && !reset) begin
      q_mem[32'(push_group) * 64 + q_wr[push_group]] = push_data;
      q_wr[push_group]++;
    end
    final_prev = final_now;
  end

endmodule

// File: verification/conv_store_tb.sv
`timescale 1ns/10ps

module conv_store_tb;

  import conv_store_pkg::*;

  logic              clk;
  logic              reset;
  logic              start;
  tile_cfg_t         cfg;
  logic              push;
  logic [1:0]        push_group;
  logic [word_w-1:0] push_data;
  logic              ddr_cmd_ready;
  logic              ddr_data_ready;
  ddr_cmd_t          cmd;
  logic              cmd_valid;
  logic [beat_w-1:0] beat_data;
  logic [31:0]       beat_adr;
  logic              beat_valid;
  logic              tile_done;

  int chk_errors;
  int cmd_count;
  int beat_count;
  int done_count;

  // feeder state
  logic        feed_on;
  logic [31:0] xs;
  logic [7:0]  ready_pattern;
  int          remaining [4];
  int          pushed [4];
  int          popped [4];
  int          rr;
  int          gap;
  int          gap_cnt;
  int          stall_left;
  int          cyc;

  int tb_errors;
  int tests;
  int passed;
  bit timed_out;

  conv_store_top conv_store_top_inst (
    .clk (clk), .reset (reset), .start (start), .cfg (cfg),
    .push (push), .push_group (push_group), .push_data (push_data),
    .ddr_cmd_ready (ddr_cmd_ready), .ddr_data_ready (ddr_data_ready),
    .cmd (cmd), .cmd_valid (cmd_valid), .beat_data (beat_data),
    .beat_adr (beat_adr), .beat_valid (beat_valid), .tile_done (tile_done)
  );

  store_checker store_checker_inst (
    .clk (clk), .reset (reset), .start (start), .cfg (cfg),
    .push (push), .push_group (push_group), .push_data (push_data),
    .cmd (cmd), .cmd_valid (cmd_valid), .beat_data (beat_data),
    .beat_adr (beat_adr), .beat_valid (beat_valid), .tile_done (tile_done),
    .errors (chk_errors), .cmd_count (cmd_count), .beat_count (beat_count),
    .done_count (done_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_word(output logic [word_w-1:0] w);
    for (int i = 0; i < 8; i++) begin
      xs = xorshift32(xs);
      w[i*32 +: 32] = xs;
    end
  endtask

  ////////////////////
  // conv core stand-in and ddr ready levels

  // occupancy seen from the fifo read strobe
  always @(posedge clk) begin
    if (reset) begin
      for (int g = 0; g < 4; g++) popped[g] = 0;
    end else if (conv_store_top_inst.rd) begin
      popped[conv_store_top_inst.rd_group]++;
    end
  end

  always @(negedge clk) begin
    int g;
    bit found;
    push  = 1'b0;
    found = 1'b0;
    if (stall_left > 0) begin
      ddr_cmd_ready = 1'b0;
      stall_left--;
    end else begin
      ddr_cmd_ready = 1'b1;
    end
    ddr_data_ready = ready_pattern[cyc % 8];
    cyc++;
    if (reset) begin
      for (int k = 0; k < 4; k++) pushed[k] = 0;
    end else if (feed_on) begin
      if (gap_cnt != 0) begin
        gap_cnt--;
      end else begin
        for (int k = 0; k < 4; k++) begin
          g = (rr + k) % 4;
          if (!found && remaining[g] > 0 && pushed[g] - popped[g] < 16) begin
            found = 1'b1;
            push  = 1'b1;
            push_group = 2'(g);
            next_word(push_data);
            remaining[g]--;
            pushed[g]++;
            rr      = g + 1;
            gap_cnt = gap;
          end
        end
      end
    end
  end

  // bounded wait for tile_done, with the stall check along the way
  task automatic wait_tile(output bit ok);
    ok = 1'b0;
    for (int i = 0; i < 20000 && !ok; i++) begin
      @(posedge clk);
      if (stall_left > 0 && (cmd_valid || beat_valid)) begin
        $display("ERROR t=%0t output appeared while ddr_cmd_ready was low", $time);
        tb_errors++;
      end
      ok = tile_done;
    end
    if (!ok) $display("ERROR t=%0t timeout waiting for tile_done", $time);
  endtask

  task automatic run_tile(logic [31:0] f [16]);
    bit ok;
    int err0;
    err0 = tb_errors + chk_errors;
    @(posedge clk);
    ready_pattern = f[11][7:0];
    gap           = f[12];
    gap_cnt       = 0;
    xs            = 32'h17b4 + f[9];
    stall_left    = f[10];
    feed_on       = 1'b1;
    for (int g = 0; g < 4; g++) remaining[g] = int'(f[5]) * int'(f[6]);
    @(negedge clk);
    cfg = '{base_adr: f[0], mode: f[1][0], ox_start: f[2][15:0], oy_start: f[3][15:0],
            of_start: f[4][15:0], pox: f[5][15:0], poy: f[6][15:0],
            of_in_2pow: f[7][3:0], ox_in_2pow: f[8][3:0]};
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    tests++;
    if (f[13] != 0) begin
      // abort mid tile
      for (int i = 0; i < int'(f[13]); i++) @(negedge clk);
      reset   = 1'b1;
      feed_on = 1'b0;
      for (int i = 0; i < 3; i++) begin
        @(posedge clk);
        if (i > 0 && (cmd_valid || beat_valid || tile_done)) begin
          $display("ERROR t=%0t outputs not low during reset", $time);
          tb_errors++;
        end
      end
      @(negedge clk);
      reset = 1'b0;
    end else begin
      wait_tile(ok);
      if (!ok) timed_out = 1'b1;
      for (int i = 0; i < 4; i++) @(posedge clk);
      feed_on = 1'b0;
      if (cmd_count != int'(f[14])) begin
        $display("FAIL t=%0t cmd_count expected %0d actual %0d", $time, f[14], cmd_count);
        tb_errors++;
      end
      if (beat_count != int'(f[15])) begin
        $display("FAIL t=%0t beat_count expected %0d actual %0d", $time, f[15], beat_count);
        tb_errors++;
      end
      if (done_count != 1) begin
        $display("FAIL t=%0t tile_done expected 1 actual %0d", $time, done_count);
        tb_errors++;
      end
    end
    if (tb_errors + chk_errors == err0 && !timed_out) passed++;
    $display("test %0d: cmds %0d beats %0d %s", tests, cmd_count, beat_count,
             (tb_errors + chk_errors == err0 && !timed_out) ? "ok" : "bad");
  endtask

  initial begin
    int fd;
    int n;
    string line;
    logic [31:0] f [16];
    reset = 1'b1;
    start = 1'b0;
    cfg = '0;
    push = 1'b0;
    push_group = '0;
    push_data = '0;
    ddr_cmd_ready = 1'b1;
    ddr_data_ready = 1'b1;
    feed_on = 1'b0;
    ready_pattern = 8'hff;
    stall_left = 0;
    cyc = 0;
    rr = 0;
    gap = 0;
    gap_cnt = 0;
    xs = 32'h17b4;
    tb_errors = 0;
    tests = 0;
    passed = 0;
    timed_out = 1'b0;
    for (int g = 0; g < 4; g++) begin
      remaining[g] = 0;
      pushed[g] = 0;
    end
    for (int i = 0; i < 10; i++) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    fd = $fopen("verification/conv_store_vectors.txt", "r");
    if (fd == 0) begin
      $display("ERROR could not open the vector file");
      tb_errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        if ($fgets(line, fd) == 0) continue;
        if (line.len() < 2 || line.getc(0) == "#") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
        if (n == 16) run_tile(f);
      end
      $fclose(fd);
    end
    $display("tests %0d passed %0d errors %0d", tests, passed, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0 && !timed_out && tests > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: conv_store.f
hdl/conv_store_pkg.sv
hdl/output_fifo_bank.sv
hdl/store_addr_gen.sv
hdl/beat_packer.sv
hdl/conv_store_ctrl.sv
hdl/conv_store_top.sv
verification/store_checker.sv
verification/conv_store_tb.sv

// File: Makefile
BIN = obj_dir/Vconv_store_tb
SRCS = $(shell cat conv_store.f)

.PHONY: run clean

$(BIN): conv_store.f $(SRCS) verification/conv_store_vectors.txt
	verilator --binary --timing -Wno-fatal --top-module conv_store_tb \
		-f conv_store.f -o Vconv_store_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/conv_store_vectors.txt
# hex: base mode ox_start oy_start of_start pox poy of_2pow ox_2pow seed_off
#      cmd_stall ready_pattern feed_gap abort_cycles exp_cmds exp_beats
# mode 0, single row, readies high
1000 0 0 0 0 4 1 6 3 0 0 ff 0 0 4 10
# mode 1 packing
2000 1 0 0 0 8 1 6 3 1 0 ff 0 0 4 10
# multi-row walk, nonzero starts
20000 0 3 2 20 4 3 7 4 2 0 ff 0 0 c 30
# same walk with a command stall
20000 0 3 2 20 4 3 7 4 2 14 ff 0 0 c 30
# toggling data ready, slow feed
3000 1 1 1 10 6 2 5 3 3 0 a5 3 0 8 18
# reset in the middle of a tile
4000 0 0 0 0 8 4 6 3 4 0 ff 1 30 0 0
# runs clean after the reset
5000 1 2 0 0 4 2 6 3 5 0 ff 0 0 8 10
# mode 0, patterned ready, feed gap
6000 0 0 1 0 6 2 6 3 6 3 33 1 0 8 30
